/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = board_tb
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
SIM_BIN    = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "** FAIL **" >> $(LOG)
	cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/board_asserts.sv */
/*
 * Host port assertions
 * Bound into the register block to watch strobe and rvalid timing
 */
`timescale 1ns/1ps

module board_asserts (
        input logic clk_i,
        input logic rst_i,
        input logic read_i,
        input logic write_i,
        input logic rvalid_i
);

        a_one_strobe: assert property (@(posedge clk_i) disable iff (rst_i)
                !(read_i && write_i))
                else $error("read and write strobes high in the same cycle");

        a_rvalid_after_read: assert property (@(posedge clk_i) disable iff (rst_i)
                read_i |=> rvalid_i)
                else $error("rvalid missing one cycle after a read strobe");

        // Response only ever follows a strobe
        a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
                rvalid_i |-> $past(read_i))
                else $error("rvalid high without a read strobe");

endmodule

bind board_ctrl_regs board_asserts u_asserts (
        .clk_i    (fpga_clk_50),
        .rst_i    (rst_i),
        .read_i   (host_req_i.read),
        .write_i  (host_req_i.write),
        .rvalid_i (host_rsp_o.rvalid)
);

/* bench/board_checker.sv */
/*
 * Board fabric checker
 * Watches the DUT ports, predicts LED, pulse and heartbeat timing
 * and compares read data with the expected values
 */
`timescale 1ns/1ps

module board_checker #(
        parameter int COLD_EXT  = 6,
        parameter int WARM_EXT  = 2,
        parameter int DEBUG_EXT = 32,
        parameter int BLINK_GAP = 10
) (
        input  logic                               clk_i,
        input  logic                               rst_i,
        input  board_pkg::host_req_t               host_req_i,
        input  board_pkg::host_rsp_t               host_rsp_i,
        input  logic [board_pkg::NUM_USER_LED-1:0] led_i,
        input  logic                               heartbeat_i,
        input  logic [2:0]                         pulse_i,     // By reset_kind_e
        input  logic [31:0]                        exp_data_i,
        input  logic [7:0]                         test_id_i,
        output int                                 err_count_o
);

        localparam int EXT_LEN [3] = '{COLD_EXT, WARM_EXT, DEBUG_EXT};

        int                                 err_cnt = 0;
        int                                 cyc = 0;
        int                                 start_c [3];
        int                                 end_c [3];     // First cycle past the pulse
        int                                 last_toggle;
        logic [2:0]                         mreq;          // Modelled request levels
        logic [board_pkg::NUM_USER_LED-1:0] mled;
        logic                               last_hb;
        logic                               rst_q;
        logic                               pend;          // Read strobe seen last cycle
        logic [31:0]                        pend_exp;
        logic [7:0]                         pend_id;
        logic                               exp_p;

        assign err_count_o = err_cnt;

        function automatic string test_name(input logic [7:0] id);
                case (id)
                8'h01:   return "reset values";
                8'h02:   return "led register";
                8'h03:   return "debounce";
                8'h04:   return "reset pulses";
                8'h05:   return "heartbeat";
                default: return "unknown test";
                endcase
        endfunction

        task automatic mismatch(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
                $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", what, exp, act);
                err_cnt++;
        endtask

        always @(posedge clk_i) begin
                rst_q <= rst_i;
                cyc   <= cyc + 1;
                if (rst_i) begin
                        if (rst_q === 1'b1 &&
                            {led_i, heartbeat_i, pulse_i, host_rsp_i.rvalid} !== '0)
                                mismatch("reset values", 32'd0,
                                         32'({led_i, heartbeat_i, pulse_i, host_rsp_i.rvalid}));
                        mreq        <= '0;
                        mled        <= '0;
                        pend        <= 1'b0;
                        last_hb     <= 1'b0;
                        last_toggle <= -1;
                        for (int k = 0; k < 3; k++) begin
                                start_c[k] <= 0;
                                end_c[k]   <= 0;
                        end
                end else begin
                        if (pend) begin
                                if (host_rsp_i.rvalid !== 1'b1) begin
                                        $display("Read response missing after the strobe in %s",
                                                 test_name(pend_id));
                                        err_cnt++;
                                end else if (host_rsp_i.rdata !== pend_exp)
                                        mismatch(test_name(pend_id), pend_exp, host_rsp_i.rdata);
                        end else if (host_rsp_i.rvalid !== 1'b0) begin
                                $display("Read response appeared without a read strobe");
                                err_cnt++;
                        end
                        pend     <= host_req_i.read;
                        pend_exp <= exp_data_i;
                        pend_id  <= test_id_i;

                        if (led_i !== mled)
                                mismatch({test_name(test_id_i), " led_o"}, 32'(mled), 32'(led_i));
                        if (host_req_i.write && host_req_i.addr == board_pkg::REG_LED)
                                mled <= host_req_i.wdata[board_pkg::NUM_USER_LED-1:0];

                        for (int k = 0; k < 3; k++) begin
                                exp_p = (cyc >= start_c[k]) && (cyc < end_c[k]);
                                if (pulse_i[k] !== exp_p)
                                        mismatch({test_name(test_id_i), " pulse"},
                                                 32'(exp_p), 32'(pulse_i[k]));
                        end
                        // Only a 0 to 1 request change on an idle pulser starts a pulse
                        if (host_req_i.write && host_req_i.addr == board_pkg::REG_RESET_REQ) begin
                                for (int k = 0; k < 3; k++) begin
                                        if (host_req_i.wdata[k] && !mreq[k] && cyc >= end_c[k]) begin
                                                start_c[k] <= cyc + 2;
                                                end_c[k]   <= cyc + 2 + EXT_LEN[k];
                                        end
                                end
                                mreq <= host_req_i.wdata[2:0];
                        end

                        if (heartbeat_i !== last_hb) begin
                                if (last_toggle >= 0 && cyc - last_toggle != BLINK_GAP)
                                        mismatch("heartbeat gap", BLINK_GAP, cyc - last_toggle);
                                last_toggle <= cyc;
                        end
                        last_hb <= heartbeat_i;
                end
        end

endmodule

/* bench/board_patterns.mem */
// test key sw op addr wdata expected hold, all hex
// op 0 idle, 1 read, 2 write; a test id of ff ends the table
01 3 0 1 1 00000000 00000000 3
01 3 0 1 2 00000000 00000000 3
02 3 0 2 1 0000005a 00000000 2
02 3 0 1 1 00000000 0000005a 3
02 3 0 2 1 ffffffff 00000000 2
02 3 0 1 1 00000000 0000007f 3
02 3 0 1 3 00000000 00000000 3
03 3 5 1 0 00000000 00000014 3
03 2 5 0 0 00000000 00000000 8
03 3 5 1 0 00000000 00000014 3
03 2 a 0 0 00000000 00000000 18
03 2 a 1 0 00000000 00000029 3
03 3 a 0 0 00000000 00000000 18
03 3 a 1 0 00000000 00000028 3
03 1 3 0 0 00000000 00000000 18
03 1 3 1 0 00000000 0000000e 3
04 3 0 2 2 00000001 00000000 c
04 3 0 2 2 00000001 00000000 c
04 3 0 1 2 00000000 00000001 3
04 3 0 2 2 00000000 00000000 4
04 3 0 2 2 00000001 00000000 c
04 3 0 2 2 00000002 00000000 8
04 3 0 2 2 00000004 00000000 28
04 3 0 2 2 00000000 00000000 4
05 3 0 0 0 00000000 00000000 30
ff 0 0 0 0 00000000 00000000 0

/* bench/board_tb.sv */
/*
 * Board fabric testbench
 * Replays the pattern table against board_top, comparing is done in the checker
 */
`timescale 1ns/1ps

module board_tb;

        localparam int DEBOUNCE_TIMEOUT = 16;
        localparam int BLINK_COUNT_MAX  = 9;
        localparam int COLD_PULSE_EXT   = 6;
        localparam int WARM_PULSE_EXT   = 2;
        localparam int DEBUG_PULSE_EXT  = 32;
        localparam int MAX_STEPS        = 64;
        localparam int FIELDS           = 8;   // Words per pattern line

        logic                               clk;
        logic                               rst_i;
        logic [board_pkg::NUM_KEYS-1:0]     key;
        logic [board_pkg::NUM_SW-1:0]       sw;
        board_pkg::host_req_t               host_req;
        board_pkg::host_rsp_t               host_rsp;
        logic [board_pkg::NUM_USER_LED-1:0] led;
        logic                               heartbeat;
        logic                               cold_reset;
        logic                               warm_reset;
        logic                               debug_reset;
        logic [31:0]                        exp_data;
        logic [7:0]                         test_id;
        logic [31:0]                        pat [0:FIELDS*MAX_STEPS-1];
        int                                 num_steps;
        int                                 hold_sum;
        int                                 cycle_cnt;
        int                                 cycle_limit;  // 0 until the table is loaded
        int                                 chk_errors;

        board_top #(
                .DEBOUNCE_TIMEOUT (DEBOUNCE_TIMEOUT),
                .BLINK_COUNT_MAX  (BLINK_COUNT_MAX)
        ) i_dut (
                .fpga_clk_50   (clk),
                .rst_i         (rst_i),
                .key_i         (key),
                .sw_i          (sw),
                .host_req_i    (host_req),
                .host_rsp_o    (host_rsp),
                .led_o         (led),
                .heartbeat_o   (heartbeat),
                .cold_reset_o  (cold_reset),
                .warm_reset_o  (warm_reset),
                .debug_reset_o (debug_reset)
        );

        board_checker #(
                .COLD_EXT  (COLD_PULSE_EXT),
                .WARM_EXT  (WARM_PULSE_EXT),
                .DEBUG_EXT (DEBUG_PULSE_EXT),
                .BLINK_GAP (BLINK_COUNT_MAX + 1)
        ) i_chk (
                .clk_i       (clk),
                .rst_i       (rst_i),
                .host_req_i  (host_req),
                .host_rsp_i  (host_rsp),
                .led_i       (led),
                .heartbeat_i (heartbeat),
                .pulse_i     ({debug_reset, warm_reset, cold_reset}),
                .exp_data_i  (exp_data),
                .test_id_i   (test_id),
                .err_count_o (chk_errors)
        );

        always #4 clk = ~clk;  // 125 MHz stand-in for the fabric clock

        task automatic finish_run(input int timeouts);
                int total;
                begin
                        total = chk_errors + timeouts;
                        $display("Errors: %0d total, %0d from checks, %0d from timeout",
                                 total, chk_errors, timeouts);
                        if (total == 0)
                                $display("** PASS **");
                        else
                                $display("** FAIL **");
                        $finish;
                end
        endtask

        // One table line, strobe on the first of its hold cycles
        task automatic apply_step(input int base);
                int hold;
                begin
                        hold = pat[base+7];
                        @(posedge clk);
                        test_id        <= pat[base][7:0];
                        key            <= pat[base+1][board_pkg::NUM_KEYS-1:0];
                        sw             <= pat[base+2][board_pkg::NUM_SW-1:0];
                        host_req.read  <= (pat[base+3] == 32'd1);
                        host_req.write <= (pat[base+3] == 32'd2);
                        host_req.addr  <= pat[base+4][board_pkg::ADDR_W-1:0];
                        host_req.wdata <= pat[base+5];
                        exp_data       <= pat[base+6];
                        repeat (hold - 1) begin
                                @(posedge clk);
                                host_req.read  <= 1'b0;
                                host_req.write <= 1'b0;
                        end
                end
        endtask

        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
                        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
                        finish_run(1);
                end
        end

        initial begin
                clk         = 1'b0;
                rst_i       = 1'b1;
                key         = '1;   // Keys released
                sw          = '0;
                host_req    = '0;
                exp_data    = '0;
                test_id     = '0;
                cycle_cnt   = 0;
                cycle_limit = 0;
                $readmemh("bench/board_patterns.mem", pat);
                num_steps = 0;
                hold_sum  = 0;
                while (num_steps < MAX_STEPS && pat[num_steps*FIELDS] !== 32'hff) begin
                        hold_sum += pat[num_steps*FIELDS+7];
                        num_steps++;
                end
                cycle_limit = hold_sum * 3 / 2;
                repeat (10) @(posedge clk);
                rst_i <= 1'b0;
                for (int s = 0; s < num_steps; s++)
                        apply_step(s * FIELDS);
                repeat (4) @(posedge clk);  // Let the last response drain
                @(negedge clk);             // Checker is done with the last edge
                finish_run(0);
        end

endmodule

/* filelist.f */
src/board_pkg.sv
src/key_debounce.sv
src/reset_pulse_gen.sv
src/heartbeat_blinker.sv
src/board_ctrl_regs.sv
src/board_top.sv
bench/board_asserts.sv
bench/board_checker.sv
bench/board_tb.sv

/* src/board_ctrl_regs.sv */
/*
 * Host register block
 * Button and switch status, user LEDs and the reset request levels
 */
`timescale 1ns/1ps

module board_ctrl_regs (
        input  logic                                fpga_clk_50,
        input  logic                                rst_i,
        input  board_pkg::host_req_t                host_req_i,
        input  logic [board_pkg::NUM_KEYS-1:0]      button_i,
        input  logic [board_pkg::NUM_SW-1:0]        sw_i,
        output board_pkg::host_rsp_t                host_rsp_o,
        output logic [board_pkg::NUM_USER_LED-1:0]  led_o,
        output logic [2:0]                          reset_req_o  // By reset_kind_e
);

        logic [board_pkg::NUM_USER_LED-1:0] led_q;
        logic [2:0]                         req_q;
        logic [board_pkg::DATA_W-1:0]       rd_data;
        logic [board_pkg::DATA_W-1:0]       rdata_q;
        logic                               rvalid_q;

        // Register writes
        always_ff @(posedge fpga_clk_50) begin
                if (rst_i) begin
                        led_q <= '0;
                        req_q <= '0;
                end else if (host_req_i.write) begin
                        case (host_req_i.addr)
                        board_pkg::REG_LED:
                                led_q <= host_req_i.wdata[board_pkg::NUM_USER_LED-1:0];
                        board_pkg::REG_RESET_REQ:
                                req_q <= host_req_i.wdata[2:0];
                        default: ;  // STATUS is read only
                        endcase
                end
        end

        // Read mux, unmapped addresses read zero
        always_comb begin
                rd_data = '0;
                case (host_req_i.addr)
                board_pkg::REG_STATUS: begin
                        rd_data[board_pkg::NUM_KEYS-1:0]               = button_i;
                        rd_data[board_pkg::NUM_KEYS +: board_pkg::NUM_SW] = sw_i;
                end
                board_pkg::REG_LED:
                        rd_data[board_pkg::NUM_USER_LED-1:0] = led_q;
                board_pkg::REG_RESET_REQ:
                        rd_data[2:0] = req_q;
                default: rd_data = '0;
                endcase
        end

        always_ff @(posedge fpga_clk_50) begin
                if (rst_i)
                        rvalid_q <= 1'b0;
                else
                        rvalid_q <= host_req_i.read;
        end

        // Read data only loads on a strobe
        always_ff @(posedge fpga_clk_50) begin
                if (host_req_i.read)
                        rdata_q <= rd_data;
        end

        assign host_rsp_o.rdata  = rdata_q;
        assign host_rsp_o.rvalid = rvalid_q;
        assign led_o             = led_q;
        assign reset_req_o       = req_q;

endmodule

/* src/board_pkg.sv */
/*
 * Board control package
 * Host register map, host port structs and the shared enums
 */
package board_pkg;

        localparam int ADDR_W       = 2;
        localparam int DATA_W       = 32;

        localparam int NUM_KEYS     = 2;  // Push buttons
        localparam int NUM_SW       = 4;  // DIP switches
        localparam int NUM_USER_LED = 7;  // LED[7:1], LED[0] is the heartbeat

        // Host visible registers
        typedef enum logic [1:0] {
                REG_STATUS    = 2'd0,
                REG_LED       = 2'd1,
                REG_RESET_REQ = 2'd2
        } reg_addr_e;

        // Bit positions inside REG_RESET_REQ
        typedef enum logic [1:0] {
                RST_COLD  = 2'd0,
                RST_WARM  = 2'd1,
                RST_DEBUG = 2'd2
        } reset_kind_e;

        typedef enum logic [1:0] {
                PULSE_IDLE,
                PULSE_ACTIVE,
                PULSE_WAIT_LOW  // Pulse done, request still high
        } pulse_state_e;

        typedef struct packed {
                logic [ADDR_W-1:0] addr;
                logic [DATA_W-1:0] wdata;
                logic              read;   // One cycle strobe
                logic              write;  // One cycle strobe
        } host_req_t;

        typedef struct packed {
                logic [DATA_W-1:0] rdata;
                logic              rvalid;
        } host_rsp_t;

endpackage

/* src/board_top.sv */
/*
 * Board fabric top level
 * Debouncer, host registers, reset pulsers and heartbeat on the 50 MHz clock
 */
`timescale 1ns/1ps

module board_top #(
        parameter int DEBOUNCE_TIMEOUT = 50000,     // 1 ms at 50 MHz
        parameter int BLINK_COUNT_MAX  = 24999999,
        parameter int COLD_PULSE_EXT   = 6,
        parameter int WARM_PULSE_EXT   = 2,
        parameter int DEBUG_PULSE_EXT  = 32
) (
        input  logic                                fpga_clk_50,
        input  logic                                rst_i,
        input  logic [board_pkg::NUM_KEYS-1:0]      key_i,        // Active low
        input  logic [board_pkg::NUM_SW-1:0]        sw_i,
        input  board_pkg::host_req_t                host_req_i,
        output board_pkg::host_rsp_t                host_rsp_o,
        output logic [board_pkg::NUM_USER_LED-1:0]  led_o,
        output logic                                heartbeat_o,
        output logic                                cold_reset_o,
        output logic                                warm_reset_o,
        output logic                                debug_reset_o
);

        logic [board_pkg::NUM_KEYS-1:0] buttons;
        logic [2:0]                     reset_req;

        key_debounce #(
                .WIDTH   (board_pkg::NUM_KEYS),
                .TIMEOUT (DEBOUNCE_TIMEOUT)
        ) u_debounce (
                .fpga_clk_50 (fpga_clk_50),
                .rst_i       (rst_i),
                .key_i       (key_i),
                .button_o    (buttons)
        );

        board_ctrl_regs u_regs (
                .fpga_clk_50 (fpga_clk_50),
                .rst_i       (rst_i),
                .host_req_i  (host_req_i),
                .button_i    (buttons),
                .sw_i        (sw_i),
                .host_rsp_o  (host_rsp_o),
                .led_o       (led_o),
                .reset_req_o (reset_req)
        );

        reset_pulse_gen #(.PULSE_EXT(COLD_PULSE_EXT)) u_cold (
                .fpga_clk_50 (fpga_clk_50),
                .rst_i       (rst_i),
                .req_i       (reset_req[board_pkg::RST_COLD]),
                .pulse_o     (cold_reset_o)
        );

        reset_pulse_gen #(.PULSE_EXT(WARM_PULSE_EXT)) u_warm (
                .fpga_clk_50 (fpga_clk_50),
                .rst_i       (rst_i),
                .req_i       (reset_req[board_pkg::RST_WARM]),
                .pulse_o     (warm_reset_o)
        );

        reset_pulse_gen #(.PULSE_EXT(DEBUG_PULSE_EXT)) u_debug (
                .fpga_clk_50 (fpga_clk_50),
                .rst_i       (rst_i),
                .req_i       (reset_req[board_pkg::RST_DEBUG]),
                .pulse_o     (debug_reset_o)
        );

        heartbeat_blinker #(.COUNT_MAX(BLINK_COUNT_MAX)) u_blink (
                .fpga_clk_50 (fpga_clk_50),
                .rst_i       (rst_i),
                .heartbeat_o (heartbeat_o)
        );

endmodule

/* src/heartbeat_blinker.sv */
/*
 * Heartbeat blinker
 * Toggles the LED every COUNT_MAX+1 fabric clock cycles
 */
`timescale 1ns/1ps

module heartbeat_blinker #(
        parameter int COUNT_MAX = 24999999  // Half period of 0.5 s at 50 MHz
) (
        input  logic fpga_clk_50,
        input  logic rst_i,
        output logic heartbeat_o
);

        localparam int CNT_W = $clog2(COUNT_MAX + 1);

        logic [CNT_W-1:0] cnt_q;

        always_ff @(posedge fpga_clk_50) begin
                if (rst_i) begin
                        cnt_q       <= '0;
                        heartbeat_o <= 1'b0;
                end else if (cnt_q == CNT_W'(COUNT_MAX)) begin
                        cnt_q       <= '0;
                        heartbeat_o <= ~heartbeat_o;  // Toggle on wrap
                end else begin
                        cnt_q <= cnt_q + 1'b1;
                end
        end

endmodule

/* src/key_debounce.sv */
/*
 * Key debouncer
 * Syncs the active-low push buttons and turns them into clean
 * active-high levels once they hold steady for TIMEOUT cycles
 */
`timescale 1ns/1ps

module key_debounce #(
        parameter int WIDTH   = 2,
        parameter int TIMEOUT = 50000
) (
        input  logic             fpga_clk_50,
        input  logic             rst_i,
        input  logic [WIDTH-1:0] key_i,      // Active low, asynchronous
        output logic [WIDTH-1:0] button_o    // Active high
);

        localparam int CNT_W = $clog2(TIMEOUT + 1);

        logic [WIDTH-1:0] key_meta_q;
        logic [WIDTH-1:0] key_sync_q;

        // Released keys read high
        always_ff @(posedge fpga_clk_50) begin
                if (rst_i) begin
                        key_meta_q <= '1;
                        key_sync_q <= '1;
                end else begin
                        key_meta_q <= key_i;
                        key_sync_q <= key_meta_q;
                end
        end

        for (genvar i = 0; i < WIDTH; i++) begin : g_key
                logic [CNT_W-1:0] cnt_q;
                logic             btn_q;

                always_ff @(posedge fpga_clk_50) begin
                        if (rst_i) begin
                                cnt_q <= '0;
                                btn_q <= 1'b0;
                        end else if (key_sync_q[i] != btn_q) begin
                                cnt_q <= '0;  // Key agrees with output
                        end else if (cnt_q == CNT_W'(TIMEOUT - 1)) begin
                                cnt_q <= '0;
                                btn_q <= ~key_sync_q[i];
                        end else begin
                                cnt_q <= cnt_q + 1'b1;
                        end
                end

                assign button_o[i] = btn_q;
        end

endmodule

/* src/reset_pulse_gen.sv */
/*
 * Reset request pulser
 * Turns a rising request level into a pulse of PULSE_EXT cycles,
 * a running pulse is never restarted
 */
`timescale 1ns/1ps

module reset_pulse_gen #(
        parameter int PULSE_EXT = 6
) (
        input  logic fpga_clk_50,
        input  logic rst_i,
        input  logic req_i,
        output logic pulse_o
);

        localparam int                CNT_W    = $clog2(PULSE_EXT + 1);
        localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(PULSE_EXT - 1);

        board_pkg::pulse_state_e state_q;
        logic [CNT_W-1:0]        cnt_q;

        // IDLE is only reached with the request low,
        // so a high request seen here is a fresh rising edge
        always_ff @(posedge fpga_clk_50) begin
                if (rst_i) begin
                        state_q <= board_pkg::PULSE_IDLE;
                        cnt_q   <= '0;
                end else begin
                        case (state_q)
                        board_pkg::PULSE_IDLE: begin
                                if (req_i) begin
                                        state_q <= board_pkg::PULSE_ACTIVE;
                                        cnt_q   <= CNT_LOAD;
                                end
                        end
                        board_pkg::PULSE_ACTIVE: begin
                                if (cnt_q == '0) begin
                                        state_q <= board_pkg::PULSE_WAIT_LOW;
                                end else begin
                                        cnt_q <= cnt_q - 1'b1;
                                end
                        end
                        board_pkg::PULSE_WAIT_LOW: begin
                                if (!req_i)
                                        state_q <= board_pkg::PULSE_IDLE;  // Rearm
                        end
                        default: state_q <= board_pkg::PULSE_IDLE;
                        endcase
                end
        end

        assign pulse_o = (state_q == board_pkg::PULSE_ACTIVE);

endmodule
